// File: build.f
common/hps_pkg.sv
common/hps_cmd_if.sv
logic/hps_cmd_framer.sv
user_io/user_io_regs.sv
user_io/ps2_key_decode.sv
file_io/file_io_ctrl.sv
logic/hps_io.sv
testbench/tb_hps_io.sv

// File: common/hps_cmd_if.sv
// interface: framed command words from a bus framer to its command handlers
`timescale 1ns/1ps

interface hps_cmd_if;
	import hps_pkg::*;

	// one cycle per accepted word
	logic          word_stb;
	hps_word_idx_t word_idx;
	// code of word 0, also valid on word 0 itself
	hps_cmd_t      cmd;
	hps_word_t     data;
	// one cycle, after the enable drops on a frame that carried words
	logic          frame_end;

	modport framer (
		output word_stb,
		output word_idx,
		output cmd,
		output data,
		output frame_end
	);

	modport handler (
		input word_stb,
		input word_idx,
		input cmd,
		input data,
		input frame_end
	);

endinterface

// File: common/hps_pkg.sv
// package: bus word and field types, command codes, keyboard constants, ps2 scan states
package hps_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// bus and field types

	// one word on the host bus
	typedef logic [15:0] hps_word_t;
	// first word of a frame
	typedef logic [15:0] hps_cmd_t;
	// word position in a frame, saturates at 31
	typedef logic [4:0]  hps_word_idx_t;

	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;

	// [7:0] scan code, [8] extended, [9] pressed, [10] toggles per event
	typedef logic [10:0] ps2_key_t;

	// download side
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_data_t;
	typedef logic [31:0] file_ext_t;

	// status-set change counter
	typedef logic [3:0] stflg_t;

	// keyboard frame parser
	typedef enum logic [1:0] {
		ps2_idle,
		ps2_collect,
		ps2_skip
	} ps2_scan_t;

	//////////////////////////////////////////////////////////////////////////////
	// command codes on the user bus

	localparam hps_cmd_t cmd_cfg        = 16'h0001;
	localparam hps_cmd_t cmd_joy_0      = 16'h0002;
	localparam hps_cmd_t cmd_joy_1      = 16'h0003;
	localparam hps_cmd_t cmd_kbd        = 16'h0005;
	localparam hps_cmd_t cmd_status     = 16'h001E;
	localparam hps_cmd_t cmd_status_set = 16'h0029;

	// command codes on the file bus
	localparam hps_cmd_t fio_file_tx     = 16'h0053;
	localparam hps_cmd_t fio_file_tx_dat = 16'h0054;
	localparam hps_cmd_t fio_file_index  = 16'h0055;
	localparam hps_cmd_t fio_file_info   = 16'h0056;

	// high byte marking a keyboard frame to ignore
	localparam logic [7:0] ps2_skip_code = 8'hFF;
	// upper nibble of the status-set reply
	localparam logic [3:0] stat_ack_tag  = 4'hA;
	// 16-bit slices in the status word
	localparam int         status_words  = 8;

endpackage

// File: file_io/file_io_ctrl.sv
// module file_io_ctrl: file download control with index, extension, address and write strobe
`timescale 1ns/1ps

module file_io_ctrl (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	hps_cmd_if.handler           bus,
	output logic                 ioctl_download,
	output hps_pkg::hps_word_t   ioctl_index,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::ioctl_data_t ioctl_dout,
	output hps_pkg::file_ext_t   ioctl_file_ext
);
	import hps_pkg::*;

	// next byte goes here, ioctl_addr shows the one being written
	ioctl_addr_t addr;
	logic        arg_stb;
	logic        dat_wr;

	// argument words only, the code word carries nothing to store
	assign arg_stb = bus.word_stb && (bus.word_idx != '0);
	assign dat_wr  = arg_stb && (bus.cmd == fio_file_tx_dat) && ioctl_download;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= 1'b0;

			if (arg_stb) begin
				case (bus.cmd)
					fio_file_index: begin
						if (bus.word_idx == 5'd1) begin
							ioctl_index <= bus.data;
						end
					end

					// high half first
					fio_file_info: begin
						if (bus.word_idx == 5'd1) begin
							ioctl_file_ext[31:16] <= bus.data;
						end else if (bus.word_idx == 5'd2) begin
							ioctl_file_ext[15:0] <= bus.data;
						end
					end

					fio_file_tx: begin
						case (bus.word_idx)
							5'd1: begin
								if (bus.data[7:0] != 8'h00) begin
									ioctl_download <= 1'b1;
									ioctl_addr     <= '0;
									addr           <= '0;
								end else begin
									// leave the byte count on the address
									if (ioctl_download) begin
										ioctl_addr <= addr;
									end
									ioctl_download <= 1'b0;
								end
							end
							5'd2: begin
								ioctl_addr[15:0] <= bus.data;
								addr[15:0]       <= bus.data;
							end
							5'd3: begin
								ioctl_addr[26:16] <= bus.data[10:0];
								addr[26:16]       <= bus.data[10:0];
							end
							default: begin
							end
						endcase
					end

					fio_file_tx_dat: begin
						if (dat_wr) begin
							ioctl_addr <= addr;
							ioctl_wr   <= 1'b1;
							addr       <= addr + 27'd1;
						end
					end

					default: begin
					end
				endcase
			end
		end
	end

	// byte lane, valid with ioctl_wr
	always_ff @(posedge clk_sys) begin
		if (dat_wr) begin
			ioctl_dout <= bus.data[7:0];
		end
	end

	a_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!arst_n) ioctl_wr |-> ioctl_download
	) else $error("ioctl_wr outside an active download");

endmodule

// File: logic/hps_cmd_framer.sv
// module hps_cmd_framer: enable and strobe to indexed words, command tag and end-of-frame pulse
`timescale 1ns/1ps

module hps_cmd_framer (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               enable,
	input  logic               io_strobe,
	input  hps_pkg::hps_word_t io_din,
	hps_cmd_if.framer          bus
);
	import hps_pkg::*;

	logic          en_q;
	logic          en_qq;
	logic          got_word;
	logic          end_due;
	logic          stb_qual;
	hps_word_idx_t cnt;
	hps_cmd_t      cmd_q;

	// registered enable dropped last cycle and the frame had words
	assign end_due = en_qq & ~en_q & got_word;

	// strobes count only inside a frame
	assign stb_qual = enable & io_strobe;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			en_q          <= 1'b0;
			en_qq         <= 1'b0;
			got_word      <= 1'b0;
			cnt           <= '0;
			bus.word_stb  <= 1'b0;
			bus.frame_end <= 1'b0;
		end else begin
			en_q          <= enable;
			en_qq         <= en_q;
			bus.word_stb  <= stb_qual;
			bus.frame_end <= end_due;

			// word counter, restarts with every frame
			if (!enable) begin
				cnt <= '0;
			end else if (stb_qual && cnt != '1) begin
				cnt <= cnt + 5'd1;
			end

			if (stb_qual) begin
				got_word <= 1'b1;
			end else if (end_due) begin
				got_word <= 1'b0;
			end
		end
	end

	// word payload, valid with word_stb
	always_ff @(posedge clk_sys) begin
		if (stb_qual) begin
			bus.word_idx <= cnt;
			bus.data     <= io_din;
			if (cnt == '0) begin
				cmd_q   <= io_din;
				bus.cmd <= io_din;
			end else begin
				bus.cmd <= cmd_q;
			end
		end
	end

	a_stb_end_apart: assert property (
		@(posedge clk_sys) disable iff (!arst_n) !(bus.word_stb && bus.frame_end)
	) else $error("word strobe and frame end in the same cycle");

endmodule

// File: logic/hps_io.sv
// module hps_io: host bridge top level with user and file bus framers and their handlers
`timescale 1ns/1ps

module hps_io (
	input  logic                   clk_sys,
	input  logic                   arst_n,

	// host bus
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  hps_pkg::hps_word_t     io_din,
	output hps_pkg::hps_word_t     io_dout,

	// core status request
	input  hps_pkg::status_t       status_in,
	input  logic                   status_set,

	// configuration and inputs
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output hps_pkg::joy_t          joystick_0,
	output hps_pkg::joy_t          joystick_1,
	output hps_pkg::status_t       status,
	output hps_pkg::ps2_key_t      ps2_key,

	// file download
	output logic                   ioctl_download,
	output hps_pkg::hps_word_t     ioctl_index,
	output logic                   ioctl_wr,
	output hps_pkg::ioctl_addr_t   ioctl_addr,
	output hps_pkg::ioctl_data_t   ioctl_dout,
	output hps_pkg::file_ext_t     ioctl_file_ext
);

	hps_cmd_if user_bus ();
	hps_cmd_if file_bus ();

	//////////////////////////////////////////////////////////////////////////////
	// framers, both on the same strobe and data lines

	hps_cmd_framer i_user_framer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.enable    (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.bus       (user_bus.framer)
	);

	hps_cmd_framer i_file_framer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.enable    (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.bus       (file_bus.framer)
	);

	//////////////////////////////////////////////////////////////////////////////
	// handlers

	user_io_regs i_user_io_regs (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.bus                (user_bus.handler),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	ps2_key_decode i_ps2_key_decode (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.bus     (user_bus.handler),
		.ps2_key (ps2_key)
	);

	file_io_ctrl i_file_io_ctrl (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.bus            (file_bus.handler),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hps_io -f build.f -o tb_hps_io \
	|| { echo "run.sh: build failed"; exit 1; }

out="$(./obj_dir/tb_hps_io 2>&1)"
echo "$out"
grep -q "Verification passed" <<< "$out" && exit 0 || exit 1

// File: testbench/tb_hps_io.sv
// module tb_hps_io: clock, reset, DUT, directed test tasks, compare tasks, timeout and summary
`timescale 1ns/1ps

module tb_hps_io;
	import hps_pkg::*;

	// tests take a few hundred cycles, about ten times that as the limit
	localparam int timeout_cycles = 4000;
	localparam int dl_bytes       = 12;

	logic        clk_sys;
	logic        arst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	hps_word_t   io_din;
	hps_word_t   io_dout;
	status_t     status_in;
	logic        status_set;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joy_t        joystick_0;
	joy_t        joystick_1;
	status_t     status;
	ps2_key_t    ps2_key;
	logic        ioctl_download;
	hps_word_t   ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;
	file_ext_t   ioctl_file_ext;

	logic [31:0] rng_state = 32'hfbd8_bf93;
	int          n_checks  = 0;
	int          n_errors  = 0;
	int          cycle_cnt = 0;
	logic        key_toggle = 1'b0;

	hps_word_t   dout_seen[$];
	ioctl_addr_t wr_addr_q[$];
	ioctl_data_t wr_data_q[$];

	hps_io i_hps_io (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	// write monitor, outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (arst_n && ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_word(input string name, input hps_word_t got, input hps_word_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_joy(input string name, input joy_t got, input joy_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_key(input string name, input ps2_key_t got, input ps2_key_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input ioctl_addr_t got, input ioctl_addr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus driver

	// one frame, strobes 4 cycles apart, io_dout sampled 3 cycles after each
	task automatic send_frame(input logic use_file, input hps_word_t words[$]);
		dout_seen.delete();
		@(negedge clk_sys);
		if (use_file) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		for (int i = 0; i < words.size(); i++) begin
			@(negedge clk_sys);
			io_din    = words[i];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			repeat (2) @(negedge clk_sys);
			dout_seen.push_back(io_dout);
		end
		@(negedge clk_sys);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		// key event lands 3 cycles after the enable drops
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic pulse_status_set();
		@(negedge clk_sys);
		status_set = 1'b1;
		repeat (2) @(negedge clk_sys);
		status_set = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_cfg();
		hps_word_t   words[$];
		logic [31:0] r;
		r = next_random();
		words.push_back(cmd_cfg);
		words.push_back(r[15:0]);
		send_frame(1'b0, words);
		check_word("buttons", hps_word_t'(buttons), hps_word_t'(r[1:0]));
		check_word("forced_scandoubler", hps_word_t'(forced_scandoubler), hps_word_t'(r[4]));
		check_word("direct_video", hps_word_t'(direct_video), hps_word_t'(r[10]));
	endtask

	task automatic test_joy();
		hps_word_t   words[$];
		joy_t        exp_j0;
		joy_t        exp_j1;
		exp_j0 = next_random();
		exp_j1 = next_random();
		words.push_back(cmd_joy_0);
		words.push_back(exp_j0[15:0]);
		words.push_back(exp_j0[31:16]);
		send_frame(1'b0, words);
		check_joy("joystick_0", joystick_0, exp_j0);
		check_joy("joystick_1", joystick_1, '0);
		words.delete();
		words.push_back(cmd_joy_1);
		words.push_back(exp_j1[15:0]);
		words.push_back(exp_j1[31:16]);
		send_frame(1'b0, words);
		check_joy("joystick_1", joystick_1, exp_j1);
		check_joy("joystick_0", joystick_0, exp_j0);
	endtask

	task automatic test_status();
		hps_word_t   words[$];
		status_t     exp_status;
		status_t     latched;
		logic [31:0] r;
		words.push_back(cmd_status);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			words.push_back(r[15:0]);
			exp_status[i*16 +: 16] = r[15:0];
		end
		send_frame(1'b0, words);
		check_status("status", status, exp_status);

		// two requests, the second snapshot is the one read back
		status_in = {next_random(), next_random(), next_random(), next_random()};
		pulse_status_set();
		latched   = {next_random(), next_random(), next_random(), next_random()};
		status_in = latched;
		pulse_status_set();
		status_in = ~latched;

		words.delete();
		words.push_back(cmd_status_set);
		for (int i = 0; i < 8; i++) begin
			words.push_back(16'h0000);
		end
		send_frame(1'b0, words);
		if (dout_seen.size() != 9) begin
			n_errors++;
			$display("status readback collected %0d words instead of 9", dout_seen.size());
		end else begin
			check_word("io_dout word 0", dout_seen[0], 16'h00A2);
			for (int i = 1; i <= 8; i++) begin
				check_word($sformatf("io_dout word %0d", i), dout_seen[i],
					latched[(i-1)*16 +: 16]);
			end
		end
		check_status("status after readback", status, exp_status);
	endtask

	// seq holds n bytes, first byte sent in the highest used position
	task automatic key_event(input logic [63:0] seq, input int n, input logic [9:0] exp_low,
		input string what);
		hps_word_t words[$];
		words.push_back(cmd_kbd);
		for (int i = n - 1; i >= 0; i--) begin
			words.push_back({8'h00, seq[8*i +: 8]});
		end
		send_frame(1'b0, words);
		key_toggle = ~key_toggle;
		check_key($sformatf("ps2_key (%s)", what), ps2_key, {key_toggle, exp_low});
	endtask

	task automatic test_kbd();
		hps_word_t words[$];
		key_event(64'h1C, 1, 10'h21C, "press");
		key_event(64'hF01C, 2, 10'h01C, "release");
		key_event(64'hE075, 2, 10'h375, "extended press");
		key_event(64'hE012_E07C, 4, 10'h37C, "print screen");
		key_event(64'hE114_77E1_F014_F077, 8, 10'h377, "pause");

		// the pause event must survive a skipped frame
		words.push_back(cmd_kbd);
		words.push_back(16'hFF00);
		words.push_back(16'h001C);
		send_frame(1'b0, words);
		check_key("ps2_key (skipped frame)", ps2_key, {key_toggle, 10'h377});
	endtask

	task automatic test_file();
		hps_word_t   words[$];
		ioctl_data_t bytes[$];
		logic [31:0] r;
		r = next_random();
		words.push_back(fio_file_index);
		words.push_back(r[15:0]);
		send_frame(1'b1, words);
		check_word("ioctl_index", ioctl_index, r[15:0]);

		r = next_random();
		words.delete();
		words.push_back(fio_file_info);
		words.push_back(r[31:16]);
		words.push_back(r[15:0]);
		send_frame(1'b1, words);
		check_word("ioctl_file_ext[31:16]", ioctl_file_ext[31:16], r[31:16]);
		check_word("ioctl_file_ext[15:0]", ioctl_file_ext[15:0], r[15:0]);

		r = next_random();
		words.delete();
		words.push_back(fio_file_tx);
		words.push_back({r[15:8], r[7:0] | 8'h01});
		send_frame(1'b1, words);
		check_word("ioctl_download", hps_word_t'(ioctl_download), 16'h0001);
		check_addr("ioctl_addr", ioctl_addr, '0);

		wr_addr_q.delete();
		wr_data_q.delete();
		words.delete();
		words.push_back(fio_file_tx_dat);
		for (int i = 0; i < dl_bytes; i++) begin
			r = next_random();
			words.push_back(r[15:0]);
			bytes.push_back(r[7:0]);
		end
		send_frame(1'b1, words);
		check_word("ioctl_wr pulse count", hps_word_t'(wr_addr_q.size()), hps_word_t'(dl_bytes));
		for (int i = 0; i < dl_bytes && i < wr_addr_q.size(); i++) begin
			check_addr($sformatf("ioctl_addr of byte %0d", i), wr_addr_q[i], ioctl_addr_t'(i));
			check_word($sformatf("ioctl_dout of byte %0d", i), hps_word_t'(wr_data_q[i]),
				hps_word_t'(bytes[i]));
		end

		r = next_random();
		words.delete();
		words.push_back(fio_file_tx);
		words.push_back({r[15:8], 8'h00});
		send_frame(1'b1, words);
		check_word("ioctl_download", hps_word_t'(ioctl_download), 16'h0000);

		// data after the stop must not write
		wr_addr_q.delete();
		wr_data_q.delete();
		words.delete();
		words.push_back(fio_file_tx_dat);
		for (int i = 0; i < 3; i++) begin
			r = next_random();
			words.push_back(r[15:0]);
		end
		send_frame(1'b1, words);
		check_word("ioctl_wr pulses after stop", hps_word_t'(wr_addr_q.size()), 16'h0000);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		arst_n     = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;

		check_word("io_dout after reset", io_dout, '0);
		check_key("ps2_key after reset", ps2_key, '0);
		check_status("status after reset", status, '0);
		check_word("ioctl_wr after reset", hps_word_t'(ioctl_wr), '0);

		test_cfg();
		test_joy();
		test_status();
		test_kbd();
		test_file();

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: user_io/ps2_key_decode.sv
// module ps2_key_decode: keyboard byte collection and key event generation per frame
`timescale 1ns/1ps

module ps2_key_decode (
	input  logic              clk_sys,
	input  logic              arst_n,
	hps_cmd_if.handler        bus,
	output hps_pkg::ps2_key_t ps2_key
);
	import hps_pkg::*;

	ps2_scan_t   state;
	logic [31:0] raw;
	logic        pressed;
	logic        extended;
	ps2_key_t    key_next;

	// break prefix F0 before the last byte
	assign pressed  = raw[15:8] != 8'hF0;
	// E0 sits before F0 on a release
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		key_next = {~ps2_key[10], pressed, extended, raw[7:0]};
		case (raw)
			// print screen pressed
			32'hE012_E07C: key_next[9:0] = 10'h37C;
			// print screen released
			32'h7CE0_F012: key_next[9:0] = 10'h17C;
			// pause pressed
			32'hF014_F077: key_next[9:0] = 10'h377;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ps2_idle;
			raw     <= '0;
			ps2_key <= '0;
		end else if (bus.frame_end) begin
			// skipped and foreign frames leave the key alone
			if (state == ps2_collect) begin
				ps2_key <= key_next;
			end
			state <= ps2_idle;
		end else if (bus.word_stb) begin
			if (bus.word_idx == '0) begin
				if (bus.cmd == cmd_kbd) begin
					state <= ps2_collect;
					raw   <= '0;
				end else begin
					state <= ps2_idle;
				end
			end else if (state == ps2_collect) begin
				if (bus.data[15:8] == ps2_skip_code) begin
					state <= ps2_skip;
				end else begin
					raw <= {raw[23:0], bus.data[7:0]};
				end
			end
		end
	end

endmodule

// File: user_io/user_io_regs.sv
// module user_io_regs: configuration, joystick and status registers with status-set readback
`timescale 1ns/1ps

module user_io_regs (
	input  logic               clk_sys,
	input  logic               arst_n,
	hps_cmd_if.handler         bus,
	input  hps_pkg::status_t   status_in,
	input  logic               status_set,
	output hps_pkg::hps_word_t io_dout,
	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic               direct_video,
	output hps_pkg::joy_t      joystick_0,
	output hps_pkg::joy_t      joystick_1,
	output hps_pkg::status_t   status
);
	import hps_pkg::*;

	hps_word_t  cfg;
	logic       status_set_q;
	logic       set_rise;
	stflg_t     stflg;
	status_t    status_req;
	logic [2:0] slot;
	logic       slot_ok;

	// config word fields
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign set_rise = status_set & ~status_set_q;

	// words 1..8 map onto status slices 0..7
	assign slot    = bus.word_idx[2:0] - 3'd1;
	assign slot_ok = (bus.word_idx != '0) &&
		(bus.word_idx <= hps_word_idx_t'(status_words));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg          <= '0;
			joystick_0   <= '0;
			joystick_1   <= '0;
			status       <= '0;
			status_set_q <= 1'b0;
			stflg        <= '0;
			io_dout      <= '0;
		end else begin
			status_set_q <= status_set;
			if (set_rise) begin
				stflg <= stflg + 4'd1;
			end

			if (bus.frame_end) begin
				io_dout <= '0;
			end else if (bus.word_stb) begin
				// reply lasts one word
				io_dout <= '0;

				if (bus.word_idx == '0) begin
					if (bus.cmd == cmd_status_set) begin
						io_dout <= {8'h00, stat_ack_tag, stflg};
					end
				end else begin
					case (bus.cmd)
						cmd_cfg: begin
							cfg <= bus.data;
						end

						cmd_joy_0: begin
							if (bus.word_idx == 5'd1) begin
								joystick_0[15:0] <= bus.data;
							end else if (bus.word_idx == 5'd2) begin
								joystick_0[31:16] <= bus.data;
							end
						end

						cmd_joy_1: begin
							if (bus.word_idx == 5'd1) begin
								joystick_1[15:0] <= bus.data;
							end else if (bus.word_idx == 5'd2) begin
								joystick_1[31:16] <= bus.data;
							end
						end

						// low slice first
						cmd_status: begin
							if (slot_ok) begin
								status[{slot, 4'b0000} +: 16] <= bus.data;
							end
						end

						cmd_status_set: begin
							if (slot_ok) begin
								io_dout <= status_req[{slot, 4'b0000} +: 16];
							end
						end

						default: begin
						end
					endcase
				end
			end
		end
	end

	// snapshot of the core's request
	always_ff @(posedge clk_sys) begin
		if (set_rise) begin
			status_req <= status_in;
		end
	end

endmodule
